// File: build.f
rtl/mem_pkg.sv
rtl/axi_lite_if.sv
rtl/lsu.sv
rtl/dmem_axi.sv
rtl/dmem_cfg.sv
rtl/mem_stage_top.sv
sim/mem_stage_assert.sv
sim/mem_stage_tb.sv

// File: rtl/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;

    // read address and data
    logic [mem_pkg::xlen-1:0]   araddr;
    logic                       arvalid;
    logic                       arready;
    logic [mem_pkg::xlen-1:0]   rdata;
    mem_pkg::axi_resp_e         rresp;
    logic                       rvalid;
    logic                       rready;

    // write address, data and response
    logic [mem_pkg::xlen-1:0]   awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [mem_pkg::xlen-1:0]   wdata;
    logic [mem_pkg::strb_w-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;
    mem_pkg::axi_resp_e         bresp;
    logic                       bvalid;
    logic                       bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

// File: rtl/dmem_axi.sv
`timescale 1ns/1ps

module dmem_axi #(
    parameter int mem_words = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [mem_pkg::wait_w-1:0] rd_wait,
    input  logic [mem_pkg::wait_w-1:0] wr_wait,
    axi_lite_if.slave                  bus
);

    localparam int idx_w = $clog2(mem_words);

    typedef enum logic [2:0] {
        idle,
        rd_wait_st,
        wr_wait_st,
        rd_resp,
        wr_resp
    } state_e;

    state_e                       state;
    logic [mem_pkg::wait_w-1:0]   cnt;

    logic [mem_pkg::xlen-1:0]     mem [mem_words];

    // latched request
    logic [idx_w-1:0]             idx_q;
    logic                         oor_q;
    logic [mem_pkg::xlen-1:0]     wdata_q;
    logic [mem_pkg::strb_w-1:0]   strb_q;
    logic [mem_pkg::xlen-1:0]     rdata_q;
    mem_pkg::axi_resp_e           resp_q;

    logic                         ar_hs;
    logic                         aw_hs;
    logic                         rd_done;
    logic                         wr_done;

    assign bus.arready = (state == idle);
    // reads win if both arrive together
    assign bus.awready = (state == idle) & bus.awvalid & bus.wvalid & ~bus.arvalid;
    assign bus.wready  = bus.awready;

    assign ar_hs = bus.arvalid & bus.arready;
    assign aw_hs = bus.awvalid & bus.awready;

    assign rd_done = (state == rd_wait_st) && (cnt == '0);
    assign wr_done = (state == wr_wait_st) && (cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (ar_hs) begin
                        state <= rd_wait_st;
                        cnt   <= rd_wait;
                    end else if (aw_hs) begin
                        state <= wr_wait_st;
                        cnt   <= wr_wait;
                    end
                end
                rd_wait_st: begin
                    if (rd_done) begin
                        state <= rd_resp;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                wr_wait_st: begin
                    if (wr_done) begin
                        state <= wr_resp;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                rd_resp: begin
                    if (bus.rready) state <= idle;
                end
                wr_resp: begin
                    if (bus.bready) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // word index past the ram end is an error
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            idx_q <= bus.araddr[2 +: idx_w];
            oor_q <= (bus.araddr >> 2) >= mem_pkg::xlen'(mem_words);
        end else if (aw_hs) begin
            idx_q   <= bus.awaddr[2 +: idx_w];
            oor_q   <= (bus.awaddr >> 2) >= mem_pkg::xlen'(mem_words);
            wdata_q <= bus.wdata;
            strb_q  <= bus.wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done | wr_done) begin
            resp_q <= oor_q ? mem_pkg::resp_slverr : mem_pkg::resp_okay;
        end
        if (rd_done) begin
            rdata_q <= oor_q ? '0 : mem[idx_q];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_done && !oor_q) begin
            for (int b = 0; b < mem_pkg::strb_w; b++) begin
                if (strb_q[b]) mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
            end
        end
    end

    assign bus.rvalid = (state == rd_resp);
    assign bus.rdata  = rdata_q;
    assign bus.rresp  = resp_q;
    assign bus.bvalid = (state == wr_resp);
    assign bus.bresp  = resp_q;

endmodule

// File: rtl/dmem_cfg.sv
`timescale 1ns/1ps

module dmem_cfg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_wen,
    input  logic                       cfg_sel,
    input  logic [mem_pkg::wait_w-1:0] cfg_wdata,
    output logic [mem_pkg::wait_w-1:0] rd_wait,
    output logic [mem_pkg::wait_w-1:0] wr_wait
);

    logic [mem_pkg::wait_w-1:0] rd_wait_q;
    logic [mem_pkg::wait_w-1:0] wr_wait_q;

    // sel 0 is the read count, sel 1 the write count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_wait_q <= '0;
            wr_wait_q <= '0;
        end else if (cfg_wen) begin
            if (cfg_sel) begin
                wr_wait_q <= cfg_wdata;
            end else begin
                rd_wait_q <= cfg_wdata;
            end
        end
    end

    assign rd_wait = rd_wait_q;
    assign wr_wait = wr_wait_q;

endmodule

// File: rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [mem_pkg::xlen-1:0] inst,
    input  logic [mem_pkg::xlen-1:0] raddr,
    input  logic [mem_pkg::xlen-1:0] waddr,
    input  logic [mem_pkg::xlen-1:0] ex_wdata,
    input  logic                     wen,
    input  logic                     req,
    output logic [mem_pkg::xlen-1:0] lsu_rdata,
    output logic                     lsu_err,

    input  logic                     prev_valid,
    output logic                     this_ready,
    input  logic                     next_ready,
    output logic                     this_valid,

    output logic                     lsu_pipe_ctrl_valid,

    axi_lite_if.master               bus
);

    mem_pkg::opcode_e   opcode;
    logic [2:0]         funct3;
    logic               lsu_busy;
    logic               ar_hs;
    logic               aw_hs;
    logic               resp_hs;

    // load context kept for the response cycle
    logic               lat_load;
    mem_pkg::load_f3_e  lat_f3;
    logic [1:0]         lat_off;

    logic [mem_pkg::xlen-1:0]   rdata_shift;
    logic [mem_pkg::xlen-1:0]   load_data;
    logic [mem_pkg::xlen-1:0]   wdata_shift;
    logic [6:0]                 wmask;

    assign opcode = mem_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    assign ar_hs   = bus.arvalid & bus.arready;
    assign aw_hs   = bus.awvalid & bus.awready;
    assign resp_hs = (bus.rvalid & bus.rready) | (bus.bvalid & bus.bready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_busy <= 1'b0;
        end else if (ar_hs | aw_hs) begin
            lsu_busy <= 1'b1;
        end else if (resp_hs) begin
            lsu_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs | aw_hs) begin
            lat_load <= ar_hs;
            lat_f3   <= mem_pkg::load_f3_e'(funct3);
            lat_off  <= raddr[1:0];
        end
    end

    assign lsu_pipe_ctrl_valid = prev_valid | lsu_busy | this_valid;

    // load alignment and extension
    assign rdata_shift = bus.rdata >> {lat_off, 3'b000};

    always_comb begin
        case (lat_f3)
            mem_pkg::lb:  load_data = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            mem_pkg::lh:  load_data = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            mem_pkg::lbu: load_data = {24'b0, rdata_shift[7:0]};
            mem_pkg::lhu: load_data = {16'b0, rdata_shift[15:0]};
            default:      load_data = rdata_shift;
        endcase
    end

    // alu result rides on raddr for non-memory ops
    always_comb begin
        if (lsu_busy) begin
            lsu_rdata = lat_load ? load_data : '0;
        end else begin
            lsu_rdata = raddr;
        end
    end

    // store alignment and byte strobes
    assign wdata_shift = ex_wdata << {waddr[1:0], 3'b000};

    always_comb begin
        wmask = 7'b0;
        if (opcode == mem_pkg::op_store) begin
            case (mem_pkg::store_f3_e'(funct3))
                mem_pkg::sb: wmask = 7'b0000001 << waddr[1:0];
                mem_pkg::sh: wmask = 7'b0000011 << waddr[1:0];
                mem_pkg::sw: wmask = 7'b0001111 << waddr[1:0];
                default:     wmask = 7'b0;
            endcase
        end
    end

    // only one access in flight
    assign bus.araddr  = raddr;
    assign bus.arvalid = req & prev_valid & ~lsu_busy;
    assign bus.rready  = next_ready;
    assign bus.awaddr  = waddr;
    assign bus.awvalid = wen & prev_valid & ~lsu_busy;
    assign bus.wdata   = wdata_shift;
    assign bus.wstrb   = wmask[3:0];
    assign bus.wvalid  = wen & prev_valid & ~lsu_busy;
    assign bus.bready  = next_ready;

    assign this_ready = ~lsu_busy & ((req & bus.arready)
                      | (wen & bus.awready & bus.wready)
                      | (~req & ~wen & next_ready));

    assign this_valid = bus.rvalid | bus.bvalid | (~lsu_busy & ~req & ~wen & prev_valid);

    assign lsu_err = (bus.rvalid & (bus.rresp == mem_pkg::resp_slverr))
                   | (bus.bvalid & (bus.bresp == mem_pkg::resp_slverr));

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

    // data and address width
    localparam int xlen = 32;

    // byte lanes per word
    localparam int strb_w = xlen / 8;

    // wait-state counter width
    localparam int wait_w = 3;

    // rv32 major opcodes
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_f3_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

endpackage

// File: rtl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int mem_words = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // execute stage side
    input  logic [mem_pkg::xlen-1:0]   inst,
    input  logic [mem_pkg::xlen-1:0]   raddr,
    input  logic [mem_pkg::xlen-1:0]   waddr,
    input  logic [mem_pkg::xlen-1:0]   ex_wdata,
    input  logic                       wen,
    input  logic                       req,
    output logic [mem_pkg::xlen-1:0]   lsu_rdata,
    output logic                       lsu_err,

    // pipeline handshake
    input  logic                       prev_valid,
    output logic                       this_ready,
    input  logic                       next_ready,
    output logic                       this_valid,
    output logic                       lsu_pipe_ctrl_valid,

    // wait-state configuration
    input  logic                       cfg_wen,
    input  logic                       cfg_sel,
    input  logic [mem_pkg::wait_w-1:0] cfg_wdata
);

    logic [mem_pkg::wait_w-1:0] rd_wait;
    logic [mem_pkg::wait_w-1:0] wr_wait;

    axi_lite_if bus ();

    lsu u_lsu (
        .clk                 (clk),
        .rst_n               (rst_n),
        .inst                (inst),
        .raddr               (raddr),
        .waddr               (waddr),
        .ex_wdata            (ex_wdata),
        .wen                 (wen),
        .req                 (req),
        .lsu_rdata           (lsu_rdata),
        .lsu_err             (lsu_err),
        .prev_valid          (prev_valid),
        .this_ready          (this_ready),
        .next_ready          (next_ready),
        .this_valid          (this_valid),
        .lsu_pipe_ctrl_valid (lsu_pipe_ctrl_valid),
        .bus                 (bus.master)
    );

    dmem_axi #(
        .mem_words (mem_words)
    ) u_dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_wait (rd_wait),
        .wr_wait (wr_wait),
        .bus     (bus.slave)
    );

    dmem_cfg u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wen   (cfg_wen),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .rd_wait   (rd_wait),
        .wr_wait   (wr_wait)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
    -f build.f --Mdir obj_dir -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem_stage_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$log"; then
    echo "no pass line found in $log"
    exit 1
fi
exit 0

// File: sim/mem_stage_assert.sv
`timescale 1ns/1ps

module mem_stage_assert (
    input logic clk,
    input logic rst_n,
    input logic arvalid,
    input logic rvalid,
    input logic bvalid
);

    // only one access in flight
    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n) !(rvalid && bvalid))
        else $error("rvalid and bvalid high together");

    a_no_ar: assert property (@(posedge clk) disable iff (!rst_n) (rvalid || bvalid) |-> !arvalid)
        else $error("arvalid high while a response is pending");

    a_reset: assert property (@(posedge clk) !rst_n |=> !rvalid && !bvalid)
        else $error("response valid after reset");

endmodule

bind dmem_axi mem_stage_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (bus.arvalid),
    .rvalid  (bus.rvalid),
    .bvalid  (bus.bvalid)
);

// File: sim/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int mem_words = 256;
    localparam int n_ops = 40;
    // fill plus six tests of at most four steps each, 24 cycles of 40 ns per step
    localparam int watchdog_ns = (mem_words + 24 * n_ops + 16) * 24 * 40;

    logic clk;
    logic rst_n;
    logic [mem_pkg::xlen-1:0] inst, raddr, waddr, ex_wdata, lsu_rdata;
    logic wen, req, prev_valid, next_ready, this_ready, this_valid, lsu_err, lsu_pipe_ctrl_valid;
    logic cfg_wen, cfg_sel;
    logic [mem_pkg::wait_w-1:0] cfg_wdata;

    logic [31:0] rng = 32'd35780;
    logic [7:0]  model_mem [mem_words*4];
    int          rd_w, wr_w, test_errs, tests_run, tests_failed, total_errs;
    string       test_name;

    mem_stage_top #(.mem_words(mem_words)) dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // lb, lh, lw, lbu, lhu
    function automatic logic [2:0] load_f3();
        logic [2:0] f;
        f = 3'(next_rand() % 5);
        if (f > 3'd2) f = f + 3'd1;
        return f;
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] word;
        int base;
        if (addr[31:2] >= 30'(mem_words)) return '0;
        base = 4 * int'(addr[31:2]);
        word = {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
        word = word >> {addr[1:0], 3'b000};
        case (f3)
            3'b000:  return {{24{word[7]}}, word[7:0]};
            3'b001:  return {{16{word[15]}}, word[15:0]};
            3'b100:  return {24'b0, word[7:0]};
            3'b101:  return {16'b0, word[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic model_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [3:0]  strb;
        logic [31:0] lanes;
        if (addr[31:2] >= 30'(mem_words)) return;
        strb = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
        strb = strb << addr[1:0];
        lanes = data << {addr[1:0], 3'b000};
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) model_mem[4 * int'(addr[31:2]) + b] = lanes[8*b +: 8];
        end
    endtask

    task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        test_errs++;
    endtask

    task automatic set_waits(input logic [2:0] rd, input logic [2:0] wr);
        cfg_wen = 1'b1;
        cfg_sel = 1'b0;
        cfg_wdata = rd;
        @(posedge clk);
        #1;
        cfg_sel = 1'b1;
        cfg_wdata = wr;
        @(posedge clk);
        #1;
        cfg_wen = 1'b0;
        rd_w = int'(rd);
        wr_w = int'(wr);
    endtask

    // one load or store, next_ready held low for stall_n cycles of the result
    task automatic access(input bit store, input logic [2:0] f3, input logic [31:0] addr,
                          input logic [31:0] data, input int stall_n);
        logic [31:0] exp_data, held;
        logic [6:0]  opc;
        logic        exp_err, held_err, seen;
        int          edges, lat, hold;
        exp_data = model_load(f3, addr);
        exp_err = addr[31:2] >= 30'(mem_words);
        opc = store ? mem_pkg::op_store : mem_pkg::op_load;
        inst = {17'b0, f3, 5'b0, opc};
        raddr = addr;
        waddr = addr;
        ex_wdata = data;
        req = !store;
        wen = store;
        prev_valid = 1'b1;
        next_ready = (stall_n == 0);
        @(negedge clk);
        while (!this_ready) @(negedge clk);
        if (lsu_pipe_ctrl_valid !== 1'b1) begin
            value_error("ctrl valid on request", 32'd1, 32'(lsu_pipe_ctrl_valid));
        end
        @(posedge clk);
        #1;
        prev_valid = 1'b0;
        req = 1'b0;
        wen = 1'b0;
        if (store) model_store(f3, addr, data);
        seen = 1'b0;
        edges = 0;
        hold = 0;
        while (1) begin
            @(negedge clk);
            if (this_ready) begin
                $display("%s: this_ready went high with an access in flight", test_name);
                test_errs++;
            end
            if (lsu_pipe_ctrl_valid !== 1'b1) begin
                value_error("ctrl valid in flight", 32'd1, 32'(lsu_pipe_ctrl_valid));
            end
            if (this_valid && !seen) begin
                seen = 1'b1;
                lat = edges;
                held = lsu_rdata;
                held_err = lsu_err;
            end else if (seen && (!this_valid || lsu_rdata !== held)) begin
                $display("%s: result did not hold while next_ready was low", test_name);
                test_errs++;
            end
            if (seen && next_ready) break;
            @(posedge clk);
            #1;
            edges++;
            if (seen) hold++;
            if (seen && hold >= stall_n) next_ready = 1'b1;
        end
        @(posedge clk);
        #1;
        if (lat != (store ? wr_w : rd_w) + 1) begin
            value_error("latency", (store ? wr_w : rd_w) + 1, lat);
        end
        if (held_err !== exp_err) value_error("lsu_err", 32'(exp_err), 32'(held_err));
        if (!store && held !== exp_data) value_error("load data", exp_data, held);
        if (lsu_pipe_ctrl_valid !== 1'b0) begin
            value_error("ctrl valid when idle", 32'd0, 32'(lsu_pipe_ctrl_valid));
        end
    endtask

    task automatic alu_pass(input logic [6:0] opc, input logic [31:0] value);
        inst = {value[31:7], opc};
        raddr = value;
        prev_valid = 1'b1;
        @(negedge clk);
        if (this_valid !== 1'b1 || dut.bus.arvalid || dut.bus.awvalid
            || dut.bus.rvalid || dut.bus.bvalid) begin
            $display("%s: pass-through not valid at once, or AXI traffic seen", test_name);
            test_errs++;
        end
        if (lsu_rdata !== value) value_error("alu result", value, lsu_rdata);
        if (lsu_pipe_ctrl_valid !== 1'b1) begin
            value_error("ctrl valid on alu op", 32'd1, 32'(lsu_pipe_ctrl_valid));
        end
        @(posedge clk);
        #1;
        prev_valid = 1'b0;
        @(negedge clk);
        if (this_valid !== 1'b0 || dut.bus.arvalid || dut.bus.awvalid
            || dut.bus.rvalid || dut.bus.bvalid) begin
            $display("%s: this_valid stayed high after prev_valid fell", test_name);
            test_errs++;
        end
        if (lsu_pipe_ctrl_valid !== 1'b0) begin
            value_error("ctrl valid when idle", 32'd0, 32'(lsu_pipe_ctrl_valid));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test();
        $display("test %-8s %s, %0d errors", test_name, test_errs ? "failed" : "ok", test_errs);
        tests_run++;
        if (test_errs != 0) tests_failed++;
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] a;
        logic [6:0]  o;
        clk = 1'b0;
        rst_n = 1'b0;
        {inst, raddr, waddr, ex_wdata} = '0;
        {wen, req, prev_valid, next_ready, cfg_wen, cfg_sel, cfg_wdata} = '0;
        {rd_w, wr_w, test_errs, tests_run, tests_failed, total_errs} = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        test_name = "fill";
        for (int i = 0; i < mem_words; i++) begin
            access(1'b1, 3'b010, 32'(4 * i), (32'(i) * 32'h9e37_79b9) ^ {16'(i), ~16'(i)}, 0);
        end
        finish_test();

        test_name = "pairs";
        for (int i = 0; i < n_ops; i++) begin
            a = 32'(next_rand() % (4 * mem_words));
            access(1'b1, 3'(next_rand() % 3), a, next_rand(), 0);
            access(1'b0, load_f3(), {a[31:2], 2'(next_rand())}, '0, 0);
        end
        finish_test();

        test_name = "waits";
        for (int i = 0; i < n_ops; i++) begin
            set_waits(3'(next_rand()), 3'(next_rand()));
            a = 32'(next_rand() % (4 * mem_words));
            access(1'b1, 3'(next_rand() % 3), a, next_rand(), 0);
            access(1'b0, load_f3(), a, '0, 0);
        end
        set_waits(3'd0, 3'd0);
        finish_test();

        test_name = "partial";
        for (int i = 0; i < n_ops; i++) begin
            a = 32'(next_rand() % (4 * mem_words));
            access(1'b1, 3'(next_rand() % 2), a, next_rand(), 0);
            access(1'b0, 3'b010, {a[31:2], 2'b00}, '0, 0);
        end
        finish_test();

        // out-of-range words alias onto ram words that must stay untouched
        test_name = "range";
        for (int i = 0; i < n_ops; i++) begin
            a = 32'(4 * mem_words + next_rand() % (16 * mem_words));
            access(1'b1, 3'b010, a, next_rand(), 0);
            access(1'b0, load_f3(), a, '0, 0);
            access(1'b0, 3'b010, 32'(a % (4 * mem_words)) & ~32'h3, '0, 0);
        end
        finish_test();

        test_name = "stall";
        set_waits(3'd2, 3'd1);
        for (int i = 0; i < n_ops; i++) begin
            a = 32'(next_rand() % (4 * mem_words));
            access(1'b1, 3'(next_rand() % 3), a, next_rand(), 1 + int'(next_rand() % 6));
            access(1'b0, load_f3(), a, '0, 1 + int'(next_rand() % 6));
        end
        finish_test();

        test_name = "alu";
        for (int i = 0; i < n_ops; i++) begin
            o = 7'(next_rand());
            if (o == mem_pkg::op_load || o == mem_pkg::op_store) o = mem_pkg::op_reg;
            alu_pass(o, next_rand());
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the DUT stopped completing accesses", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
